// ==== hw/menuPkg.sv ====
package menuPkg;

	////////////////////////////////////////
	// Display geometry
	////////////////////////////////////////
	localparam int LCD_CHARS = 32;
	// Line 1 starts here
	localparam int LINE_CHARS = 16;
	localparam int MENU_TEXTS = 7;

	typedef logic [7:0] char_t;
	typedef logic [4:0] lcdAddr_t;
	// Leftmost character sits in the top byte
	typedef char_t [LINE_CHARS-1:0] lcdLine_t;

	// Cleared RAM byte
	localparam char_t CHAR_SPACE = 8'h20;
	// Edit character after reset, 'A'
	localparam char_t CHAR_START = 8'h41;

	// Column range and the skipped gap between 7 and 10
	localparam logic [3:0] COLUMN_LOW = 4'd2;
	localparam logic [3:0] COLUMN_HIGH = 4'd15;
	localparam logic [3:0] GAP_LOW = 4'd7;
	localparam logic [3:0] GAP_HIGH = 4'd10;

	////////////////////////////////////////
	// Menu text
	////////////////////////////////////////
	typedef enum logic [2:0] {
		MAIN_TITLE    = 3'd0,
		OPT_DISPLAY   = 3'd1,
		OPT_MODIFY    = 3'd2,
		OPT_CLEAR     = 3'd3,
		CONFIRM_TITLE = 3'd4,
		OPT_YES       = 3'd5,
		OPT_NO        = 3'd6
	} menuText_t;

	// One entry per menuText_t value, same order
	localparam lcdLine_t menuTextTable [MENU_TEXTS] = '{
		"MAIN MENU       ",
		"DISPLAY RAM     ",
		"MODIFY RAM      ",
		"CLEAR RAM       ",
		"ARE YOU SURE?   ",
		"YES             ",
		"NO              "
	};

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////
	typedef enum logic [2:0] {NONE, MENU, SELECT, ROTATE, COLUMN} eventKind_t;

	// Forward means knob left or column right
	typedef struct packed {
		eventKind_t kind;
		logic       forward;
	} userEvent_t;

	typedef enum logic [1:0] {TEXT, RAM, SINGLE} lcdSource_t;

	typedef struct packed {
		lcdSource_t source;
		menuText_t  textId;
		lcdAddr_t   firstAddr;
		lcdAddr_t   lastAddr;
		char_t      charValue;
	} lcdJob_t;

	typedef struct packed {
		logic     enable;
		lcdAddr_t addr;
		char_t    data;
	} ramWrite_t;

	// Screens of the menu FSM
	typedef enum logic [2:0] {
		SCR_MAIN, SCR_CONFIRM, SCR_DISPLAY, SCR_POS_SEL, SCR_CHAR_SEL
	} screen_t;

endpackage

// ==== hw/localCharRam.sv ====
module localCharRam import menuPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  ramWrite_t write,
	input  logic      clear,
	input  lcdAddr_t  readAddr,
	output char_t     readData
);

	char_t mem [LCD_CHARS];

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////
	// Whole array to spaces in one cycle
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			for (int i = 0; i < LCD_CHARS; i++) begin
				mem[i] <= CHAR_SPACE;
			end
		end else if (write.enable) begin
			mem[write.addr] <= write.data;
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////
	// Data one cycle after the address
	always_ff @(posedge clk) begin
		readData <= mem[readAddr];
	end

endmodule

// ==== hw/inputDecoder.sv ====
module inputDecoder import menuPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rotaryEvent,
	input  logic       rotaryLeft,
	input  logic       rotaryBtn,
	input  logic       columnLeftBtn,
	input  logic       columnRightBtn,
	input  logic       menuBtn,
	output userEvent_t userEvent
);

	logic rotaryBtnPrev;
	logic columnLeftPrev;
	logic columnRightPrev;
	logic menuPrev;
	logic selectEdge;
	logic columnLeftEdge;
	logic columnRightEdge;
	logic menuEdge;
	userEvent_t nextEvent;

	////////////////////////////////////////
	// Rising edges of the button levels
	////////////////////////////////////////
	assign selectEdge = rotaryBtn && !rotaryBtnPrev;
	assign columnLeftEdge = columnLeftBtn && !columnLeftPrev;
	assign columnRightEdge = columnRightBtn && !columnRightPrev;
	assign menuEdge = menuBtn && !menuPrev;

	// One event per cycle, rest dropped
	always_comb begin
		nextEvent.kind = NONE;
		nextEvent.forward = 1'b0;
		if (menuEdge) begin
			nextEvent.kind = MENU;
		end else if (selectEdge) begin
			nextEvent.kind = SELECT;
		end else if (rotaryEvent) begin
			nextEvent.kind = ROTATE;
			nextEvent.forward = rotaryLeft;
		end else if (columnLeftEdge || columnRightEdge) begin
			// Right wins when both press together
			nextEvent.kind = COLUMN;
			nextEvent.forward = columnRightEdge;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rotaryBtnPrev <= 1'b0;
			columnLeftPrev <= 1'b0;
			columnRightPrev <= 1'b0;
			menuPrev <= 1'b0;
			userEvent.kind <= NONE;
			userEvent.forward <= 1'b0;
		end else begin
			rotaryBtnPrev <= rotaryBtn;
			columnLeftPrev <= columnLeftBtn;
			columnRightPrev <= columnRightBtn;
			menuPrev <= menuBtn;
			userEvent <= nextEvent;
		end
	end

endmodule

// ==== hw/menuSequencer.sv ====
module menuSequencer import menuPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  userEvent_t userEvent,
	input  logic       jobDone,
	output lcdJob_t    job,
	output logic       jobStart,
	output ramWrite_t  ramWrite,
	output logic       ramClear,
	output logic       enableCursor,
	output lcdAddr_t   cursorPos
);

	screen_t screen;
	menuText_t mainOption;
	// Option line queued behind a title job
	menuText_t pendingText;
	logic optionPending;
	logic confirmYes;
	logic busy;
	logic initDraw;
	logic [3:0] editColumn;
	logic [3:0] editRow;
	logic [3:0] nextColumn;
	logic [3:0] nextRow;
	char_t editChar;
	char_t nextChar;

	////////////////////////////////////////
	// Job builders
	////////////////////////////////////////
	// Title on line 0, option on line 1
	function automatic lcdJob_t textJob(input menuText_t id, input logic secondLine);
		lcdJob_t j;
		j.source = TEXT;
		j.textId = id;
		j.firstAddr = secondLine ? lcdAddr_t'(LINE_CHARS) : lcdAddr_t'(0);
		j.lastAddr = secondLine ? lcdAddr_t'(LCD_CHARS - 1) : lcdAddr_t'(LINE_CHARS - 1);
		j.charValue = CHAR_SPACE;
		return j;
	endfunction

	// Full page of RAM, or one character
	function automatic lcdJob_t charJob(input lcdSource_t src, input lcdAddr_t addr,
			input char_t value);
		lcdJob_t j;
		j.source = src;
		j.textId = MAIN_TITLE;
		j.firstAddr = (src == RAM) ? lcdAddr_t'(0) : addr;
		j.lastAddr = (src == RAM) ? lcdAddr_t'(LCD_CHARS - 1) : addr;
		j.charValue = value;
		return j;
	endfunction

	// Main menu options wrap both ways
	function automatic menuText_t stepOption(input menuText_t opt, input logic fwd);
		case (opt)
			OPT_DISPLAY: return fwd ? OPT_MODIFY : OPT_CLEAR;
			OPT_MODIFY: return fwd ? OPT_CLEAR : OPT_DISPLAY;
			default: return fwd ? OPT_DISPLAY : OPT_MODIFY;
		endcase
	endfunction

	// Columns 2..7 and 10..15
	function automatic logic [3:0] stepColumn(input logic [3:0] col, input logic fwd);
		if (fwd) begin
			if (col == GAP_LOW) return GAP_HIGH;
			if (col == COLUMN_HIGH) return COLUMN_LOW;
			return col + 4'd1;
		end
		if (col == GAP_HIGH) return GAP_LOW;
		if (col == COLUMN_LOW) return COLUMN_HIGH;
		return col - 4'd1;
	endfunction

	////////////////////////////////////////
	// Edit character preview
	////////////////////////////////////////
	assign editChar = {editColumn, editRow};
	assign nextChar = {nextColumn, nextRow};

	always_comb begin
		nextColumn = editColumn;
		nextRow = editRow;
		if (userEvent.kind == ROTATE) begin
			nextRow = userEvent.forward ? editRow + 4'd1 : editRow - 4'd1;
		end else if (userEvent.kind == COLUMN) begin
			nextColumn = stepColumn(editColumn, userEvent.forward);
		end
	end

	// Cursor only once the page is drawn
	assign enableCursor = (screen == SCR_POS_SEL) && !busy;

	////////////////////////////////////////
	// Menu FSM
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			screen <= SCR_MAIN;
			mainOption <= OPT_DISPLAY;
			optionPending <= 1'b0;
			confirmYes <= 1'b1;
			busy <= 1'b0;
			initDraw <= 1'b1;
			editColumn <= CHAR_START[7:4];
			editRow <= CHAR_START[3:0];
			cursorPos <= '0;
			jobStart <= 1'b0;
			ramWrite.enable <= 1'b0;
			ramClear <= 1'b0;
		end else begin
			jobStart <= 1'b0;
			ramWrite.enable <= 1'b0;
			ramClear <= 1'b0;
			if (userEvent.kind == MENU || initDraw) begin
				// Aborts any running job
				initDraw <= 1'b0;
				screen <= SCR_MAIN;
				editColumn <= CHAR_START[7:4];
				editRow <= CHAR_START[3:0];
				job <= textJob(MAIN_TITLE, 1'b0);
				pendingText <= mainOption;
				optionPending <= 1'b1;
				jobStart <= 1'b1;
				busy <= 1'b1;
			end else if (busy) begin
				// Other input lost while drawing
				if (jobDone && optionPending) begin
					job <= textJob(pendingText, 1'b1);
					optionPending <= 1'b0;
					jobStart <= 1'b1;
				end else if (jobDone) begin
					busy <= 1'b0;
				end
			end else begin
				case (screen)
					SCR_MAIN: begin
						if (userEvent.kind == ROTATE) begin
							mainOption <= stepOption(mainOption, userEvent.forward);
							job <= textJob(stepOption(mainOption, userEvent.forward), 1'b1);
							jobStart <= 1'b1;
							busy <= 1'b1;
						end else if (userEvent.kind == SELECT) begin
							jobStart <= 1'b1;
							busy <= 1'b1;
							if (mainOption == OPT_CLEAR) begin
								screen <= SCR_CONFIRM;
								confirmYes <= 1'b1;
								job <= textJob(CONFIRM_TITLE, 1'b0);
								pendingText <= OPT_YES;
								optionPending <= 1'b1;
							end else begin
								screen <= (mainOption == OPT_MODIFY) ? SCR_POS_SEL : SCR_DISPLAY;
								job <= charJob(RAM, '0, CHAR_SPACE);
							end
						end
					end
					SCR_CONFIRM: begin
						if (userEvent.kind == ROTATE) begin
							confirmYes <= !confirmYes;
							job <= textJob(confirmYes ? OPT_NO : OPT_YES, 1'b1);
							jobStart <= 1'b1;
							busy <= 1'b1;
						end else if (userEvent.kind == SELECT) begin
							// YES clears, then back to the display option
							ramClear <= confirmYes;
							mainOption <= confirmYes ? OPT_DISPLAY : OPT_CLEAR;
							pendingText <= confirmYes ? OPT_DISPLAY : OPT_CLEAR;
							screen <= SCR_MAIN;
							job <= textJob(MAIN_TITLE, 1'b0);
							optionPending <= 1'b1;
							jobStart <= 1'b1;
							busy <= 1'b1;
						end
					end
					SCR_DISPLAY: begin
						if (userEvent.kind == SELECT) begin
							screen <= SCR_MAIN;
							job <= textJob(MAIN_TITLE, 1'b0);
							pendingText <= mainOption;
							optionPending <= 1'b1;
							jobStart <= 1'b1;
							busy <= 1'b1;
						end
					end
					SCR_POS_SEL: begin
						// Position wraps mod 32
						if (userEvent.kind == ROTATE) begin
							cursorPos <= userEvent.forward ? cursorPos + 5'd1 : cursorPos - 5'd1;
						end else if (userEvent.kind == SELECT) begin
							screen <= SCR_CHAR_SEL;
						end
					end
					SCR_CHAR_SEL: begin
						if (userEvent.kind == ROTATE || userEvent.kind == COLUMN) begin
							editColumn <= nextColumn;
							editRow <= nextRow;
							job <= charJob(SINGLE, cursorPos, nextChar);
							jobStart <= 1'b1;
							busy <= 1'b1;
						end else if (userEvent.kind == SELECT) begin
							// Commit and go back to moving the cursor
							ramWrite.enable <= 1'b1;
							ramWrite.addr <= cursorPos;
							ramWrite.data <= editChar;
							screen <= SCR_POS_SEL;
						end
					end
					default: screen <= SCR_MAIN;
				endcase
			end
		end
	end

endmodule

// ==== hw/lcdWriter.sv ====
module lcdWriter import menuPkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  lcdJob_t  job,
	input  logic     jobStart,
	output logic     jobDone,
	output lcdAddr_t ramAddr,
	input  char_t    ramData,
	output lcdAddr_t lcdAddr,
	output char_t    lcdData,
	output logic     lcdW
);

	logic busy;
	// Low is the setup cycle, high the write cycle
	logic writePhase;
	lcdJob_t curJob;
	lcdAddr_t curAddr;
	logic [3:0] textOffset;
	char_t fetched;

	////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////
	// A new start restarts a running job
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			writePhase <= 1'b0;
		end else if (jobStart) begin
			busy <= 1'b1;
			writePhase <= 1'b0;
		end else if (busy) begin
			writePhase <= !writePhase;
			if (writePhase && curAddr == curJob.lastAddr) begin
				busy <= 1'b0;
			end
		end
	end

	// Job and address latch
	always_ff @(posedge clk) begin
		if (jobStart) begin
			curJob <= job;
			curAddr <= job.firstAddr;
		end else if (busy && writePhase) begin
			curAddr <= curAddr + 5'd1;
		end
	end

	////////////////////////////////////////
	// Character fetch
	////////////////////////////////////////
	// Offset within the line picks the text byte
	assign textOffset = 4'(LINE_CHARS - 1) - curAddr[3:0];

	always_ff @(posedge clk) begin
		if (busy && !writePhase) begin
			fetched <= (curJob.source == SINGLE) ? curJob.charValue
				: menuTextTable[curJob.textId][textOffset];
		end
	end

	// RAM read runs alongside the setup cycle
	assign ramAddr = curAddr;

	assign lcdAddr = curAddr;
	assign lcdData = (curJob.source == RAM) ? ramData : fetched;
	assign lcdW = busy && writePhase;
	assign jobDone = lcdW && (curAddr == curJob.lastAddr);

endmodule

// ==== hw/lcdMenuTop.sv ====
module lcdMenuTop import menuPkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     rotaryEvent,
	input  logic     rotaryLeft,
	input  logic     rotaryBtn,
	input  logic     columnLeftBtn,
	input  logic     columnRightBtn,
	input  logic     menuBtn,
	output lcdAddr_t lcdAddr,
	output char_t    lcdData,
	output logic     lcdW,
	output logic     enableCursor,
	output lcdAddr_t cursorPos
);

	userEvent_t userEvent;
	lcdJob_t job;
	logic jobStart;
	logic jobDone;
	ramWrite_t ramWrite;
	logic ramClear;
	lcdAddr_t ramAddr;
	char_t ramData;

	////////////////////////////////////////
	// Decode, execute, result
	////////////////////////////////////////
	inputDecoder inputDecoder_inst (
		.clk           (clk),
		.reset         (reset),
		.rotaryEvent   (rotaryEvent),
		.rotaryLeft    (rotaryLeft),
		.rotaryBtn     (rotaryBtn),
		.columnLeftBtn (columnLeftBtn),
		.columnRightBtn(columnRightBtn),
		.menuBtn       (menuBtn),
		.userEvent     (userEvent)
	);

	menuSequencer menuSequencer_inst (
		.clk         (clk),
		.reset       (reset),
		.userEvent   (userEvent),
		.jobDone     (jobDone),
		.job         (job),
		.jobStart    (jobStart),
		.ramWrite    (ramWrite),
		.ramClear    (ramClear),
		.enableCursor(enableCursor),
		.cursorPos   (cursorPos)
	);

	lcdWriter lcdWriter_inst (
		.clk     (clk),
		.reset   (reset),
		.job     (job),
		.jobStart(jobStart),
		.jobDone (jobDone),
		.ramAddr (ramAddr),
		.ramData (ramData),
		.lcdAddr (lcdAddr),
		.lcdData (lcdData),
		.lcdW    (lcdW)
	);

	// Character store
	localCharRam localCharRam_inst (
		.clk     (clk),
		.reset   (reset),
		.write   (ramWrite),
		.clear   (ramClear),
		.readAddr(ramAddr),
		.readData(ramData)
	);

endmodule

// ==== sim/tbClockGen.sv ====
module tbClockGen (
	output logic clk,
	output logic reset
);

	// Period of 10 time units
	initial begin
		clk = 1'b0;
		forever begin
			#5;
			clk = ~clk;
		end
	end

	// Reset held over the first 10 rising edges
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== sim/lcdMenuTb.sv ====
module lcdMenuTb import menuPkg::*; ();

	typedef enum logic [2:0] {
		IDLE, KNOB_LEFT, KNOB_RIGHT, KNOB_PRESS, COL_LEFT, COL_RIGHT, MENU_PRESS
	} action_t;

	// One table row holds an input and the screen expected once it settles
	typedef struct packed {
		action_t  action;
		lcdLine_t line0;
		lcdLine_t line1;
		logic     cursorOn;
		lcdAddr_t cursor;
	} stepRow_t;

	localparam int MAX_ROWS = 96;
	localparam int QUIET_CYCLES = 100;
	localparam int ROW_CYCLES = 120;
	localparam int CLOCK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;

	// Expected menu text padded to a full line
	localparam lcdLine_t MAIN_LINE = "MAIN MENU       ";
	localparam lcdLine_t DISPLAY_LINE = "DISPLAY RAM     ";
	localparam lcdLine_t MODIFY_LINE = "MODIFY RAM      ";
	localparam lcdLine_t CLEAR_LINE = "CLEAR RAM       ";
	localparam lcdLine_t SURE_LINE = "ARE YOU SURE?   ";
	localparam lcdLine_t YES_LINE = "YES             ";
	localparam lcdLine_t NO_LINE = "NO              ";

	logic clk;
	logic reset;
	logic rotaryEvent;
	logic rotaryLeft;
	logic rotaryBtn;
	logic columnLeftBtn;
	logic columnRightBtn;
	logic menuBtn;
	lcdAddr_t lcdAddr;
	char_t lcdData;
	logic lcdW;
	logic enableCursor;
	lcdAddr_t cursorPos;

	// What the LCD shows
	lcdLine_t shadow0;
	lcdLine_t shadow1;
	// Reference state for RAM, drawn page and edit character
	char_t ramModel [LCD_CHARS];
	char_t pageModel [LCD_CHARS];
	logic [3:0] editCol;
	logic [3:0] editRow;
	lcdAddr_t cursorModel;
	stepRow_t stepTable [MAX_ROWS];
	int rowCount;
	int seed;
	logic tableReady;

	tbClockGen clockGen_inst (
		.clk  (clk),
		.reset(reset)
	);

	lcdMenuTop lcdMenuTop_inst (
		.clk           (clk),
		.reset         (reset),
		.rotaryEvent   (rotaryEvent),
		.rotaryLeft    (rotaryLeft),
		.rotaryBtn     (rotaryBtn),
		.columnLeftBtn (columnLeftBtn),
		.columnRightBtn(columnRightBtn),
		.menuBtn       (menuBtn),
		.lcdAddr       (lcdAddr),
		.lcdData       (lcdData),
		.lcdW          (lcdW),
		.enableCursor  (enableCursor),
		.cursorPos     (cursorPos)
	);

	// Shadow follows every LCD write with the leftmost char in the top byte
	always @(negedge clk) begin
		if (lcdW === 1'b1) begin
			if (lcdAddr < LINE_CHARS) begin
				shadow0[LINE_CHARS - 1 - lcdAddr] = lcdData;
			end else begin
				shadow1[LCD_CHARS - 1 - lcdAddr] = lcdData;
			end
		end
	end

	////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////
	// Step once, then keep going past the gap and below the low end
	function automatic logic [3:0] nextColumn(input logic [3:0] col, input logic right);
		logic [3:0] c;
		c = right ? col + 4'd1 : col - 4'd1;
		while (c < COLUMN_LOW || (c > GAP_LOW && c < GAP_HIGH)) begin
			c = right ? c + 4'd1 : c - 4'd1;
		end
		return c;
	endfunction

	function automatic lcdLine_t pageLine(input int line);
		lcdLine_t l;
		for (int i = 0; i < LINE_CHARS; i++) begin
			l[LINE_CHARS - 1 - i] = pageModel[line * LINE_CHARS + i];
		end
		return l;
	endfunction

	function automatic action_t pickAction(input action_t a, input action_t b);
		if ($random(seed) & 1) begin
			return a;
		end
		return b;
	endfunction

	task addRow(input action_t a, input lcdLine_t l0, input lcdLine_t l1, input logic on);
		stepTable[rowCount].action = a;
		stepTable[rowCount].line0 = l0;
		stepTable[rowCount].line1 = l1;
		stepTable[rowCount].cursorOn = on;
		stepTable[rowCount].cursor = cursorModel;
		rowCount++;
	endtask

	task addMenuRow(input action_t a, input lcdLine_t option);
		addRow(a, MAIN_LINE, option, 1'b0);
	endtask

	// Full page redraw from RAM
	task showPage(input action_t a, input logic on);
		for (int i = 0; i < LCD_CHARS; i++) begin
			pageModel[i] = ramModel[i];
		end
		addRow(a, pageLine(0), pageLine(1), on);
	endtask

	// Knob left moves forward modulo 32
	task moveCursor(input action_t a);
		cursorModel = (a == KNOB_LEFT) ? cursorModel + 5'd1 : cursorModel - 5'd1;
		addRow(a, pageLine(0), pageLine(1), 1'b1);
	endtask

	// Row is the low nibble, column the high nibble
	task editStep(input action_t a);
		case (a)
			KNOB_LEFT: editRow = editRow + 4'd1;
			KNOB_RIGHT: editRow = editRow - 4'd1;
			COL_RIGHT: editCol = nextColumn(editCol, 1'b1);
			default: editCol = nextColumn(editCol, 1'b0);
		endcase
		pageModel[cursorModel] = {editCol, editRow};
		addRow(a, pageLine(0), pageLine(1), 1'b0);
	endtask

	task commitChar();
		ramModel[cursorModel] = {editCol, editRow};
		addRow(KNOB_PRESS, pageLine(0), pageLine(1), 1'b1);
	endtask

	// Menu button brings the edit character back to 'A'
	task menuPress(input lcdLine_t option);
		editCol = 4'h4;
		editRow = 4'h1;
		addMenuRow(MENU_PRESS, option);
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////
	task buildTable();
		int moves;
		int rowSteps;
		int colSteps;
		// Screen after reset
		addMenuRow(IDLE, DISPLAY_LINE);
		// Option wrap in both directions
		addMenuRow(KNOB_LEFT, MODIFY_LINE);
		addMenuRow(KNOB_LEFT, CLEAR_LINE);
		addMenuRow(KNOB_LEFT, DISPLAY_LINE);
		addMenuRow(KNOB_RIGHT, CLEAR_LINE);
		addMenuRow(KNOB_RIGHT, MODIFY_LINE);
		addMenuRow(KNOB_RIGHT, DISPLAY_LINE);
		// Display page of a fresh RAM
		showPage(KNOB_PRESS, 1'b0);
		addMenuRow(KNOB_PRESS, DISPLAY_LINE);
		// Modify with random cursor and character steps
		addMenuRow(KNOB_LEFT, MODIFY_LINE);
		showPage(KNOB_PRESS, 1'b1);
		moves = 1 + ($random(seed) & 7);
		repeat (moves) moveCursor(pickAction(KNOB_LEFT, KNOB_RIGHT));
		// Character select draws nothing until a change
		addRow(KNOB_PRESS, pageLine(0), pageLine(1), 1'b0);
		rowSteps = 1 + ($random(seed) & 3);
		colSteps = 2 + ($random(seed) & 7);
		repeat (rowSteps) editStep(pickAction(KNOB_LEFT, KNOB_RIGHT));
		repeat (colSteps) editStep(pickAction(COL_RIGHT, COL_LEFT));
		commitChar();
		menuPress(MODIFY_LINE);
		addMenuRow(KNOB_RIGHT, DISPLAY_LINE);
		showPage(KNOB_PRESS, 1'b0);
		addMenuRow(KNOB_PRESS, DISPLAY_LINE);
		// Clear answered NO keeps the RAM
		addMenuRow(KNOB_RIGHT, CLEAR_LINE);
		addRow(KNOB_PRESS, SURE_LINE, YES_LINE, 1'b0);
		addRow(KNOB_LEFT, SURE_LINE, NO_LINE, 1'b0);
		addMenuRow(KNOB_PRESS, CLEAR_LINE);
		addMenuRow(KNOB_LEFT, DISPLAY_LINE);
		showPage(KNOB_PRESS, 1'b0);
		addMenuRow(KNOB_PRESS, DISPLAY_LINE);
		// Clear answered YES
		addMenuRow(KNOB_RIGHT, CLEAR_LINE);
		addRow(KNOB_PRESS, SURE_LINE, YES_LINE, 1'b0);
		for (int i = 0; i < LCD_CHARS; i++) begin
			ramModel[i] = CHAR_SPACE;
		end
		addMenuRow(KNOB_PRESS, DISPLAY_LINE);
		showPage(KNOB_PRESS, 1'b0);
		addMenuRow(KNOB_PRESS, DISPLAY_LINE);
		// Menu button aborts character select
		addMenuRow(KNOB_LEFT, MODIFY_LINE);
		showPage(KNOB_PRESS, 1'b1);
		addRow(KNOB_PRESS, pageLine(0), pageLine(1), 1'b0);
		editStep(COL_RIGHT);
		menuPress(MODIFY_LINE);
		showPage(KNOB_PRESS, 1'b1);
		addRow(KNOB_PRESS, pageLine(0), pageLine(1), 1'b0);
		// From 'A' across the 7 to 10 gap and back
		repeat (4) editStep(COL_RIGHT);
		editStep(COL_LEFT);
		editStep(KNOB_LEFT);
		// Low end of the columns wraps to 15 and back
		repeat (6) editStep(COL_LEFT);
		editStep(COL_RIGHT);
		// Row wraps below zero
		repeat (3) editStep(KNOB_RIGHT);
		tableReady = 1'b1;
	endtask

	////////////////////////////////////////
	// Drive and compare
	////////////////////////////////////////
	// Knob pulse lasts one cycle and buttons two
	task applyAction(input action_t a);
		@(posedge clk);
		#1;
		case (a)
			KNOB_LEFT: begin
				rotaryEvent = 1'b1;
				rotaryLeft = 1'b1;
			end
			KNOB_RIGHT: begin
				rotaryEvent = 1'b1;
				rotaryLeft = 1'b0;
			end
			KNOB_PRESS: rotaryBtn = 1'b1;
			COL_LEFT: columnLeftBtn = 1'b1;
			COL_RIGHT: columnRightBtn = 1'b1;
			MENU_PRESS: menuBtn = 1'b1;
			default: ;
		endcase
		@(posedge clk);
		#1;
		rotaryEvent = 1'b0;
		@(posedge clk);
		#1;
		rotaryBtn = 1'b0;
		columnLeftBtn = 1'b0;
		columnRightBtn = 1'b0;
		menuBtn = 1'b0;
	endtask

	task checkLine(input string name, input lcdLine_t got, input lcdLine_t expected);
		if (got !== expected) begin
			$display("ERROR at %0t: %s is \"%s\", expected \"%s\"", $time, name, got, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "LCD line mismatch");
		end
	endtask

	task checkCursor(input logic gotOn, input lcdAddr_t gotPos, input logic expOn,
			input lcdAddr_t expPos);
		if (gotOn !== expOn || gotPos !== expPos) begin
			$display("ERROR at %0t: enableCursor/cursorPos is %b/%0d, expected %b/%0d",
				$time, gotOn, gotPos, expOn, expPos);
			$display("SIMULATION FAILED");
			$fatal(1, "Cursor mismatch");
		end
	endtask

	initial begin
		rotaryEvent = 1'b0;
		rotaryLeft = 1'b0;
		rotaryBtn = 1'b0;
		columnLeftBtn = 1'b0;
		columnRightBtn = 1'b0;
		menuBtn = 1'b0;
		shadow0 = '0;
		shadow1 = '0;
		seed = 3776;
		rowCount = 0;
		tableReady = 1'b0;
		for (int i = 0; i < LCD_CHARS; i++) begin
			ramModel[i] = CHAR_SPACE;
			pageModel[i] = CHAR_SPACE;
		end
		// Edit character starts at 'A'
		editCol = 4'h4;
		editRow = 4'h1;
		cursorModel = '0;
		buildTable();
		wait (reset === 1'b0);
		for (int r = 0; r < rowCount; r++) begin
			applyAction(stepTable[r].action);
			repeat (QUIET_CYCLES) @(posedge clk);
			@(negedge clk);
			checkLine("line0", shadow0, stepTable[r].line0);
			checkLine("line1", shadow1, stepTable[r].line1);
			checkCursor(enableCursor, cursorPos, stepTable[r].cursorOn, stepTable[r].cursor);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

	// Run length follows the table size
	initial begin
		int limit;
		wait (tableReady === 1'b1);
		limit = (rowCount * ROW_CYCLES + RESET_CYCLES) * CLOCK_PERIOD;
		#(limit);
		$display("SIMULATION FAILED");
		$fatal(1, "Watchdog expired, the table did not finish within %0d time units", limit);
	end

endmodule

// ==== project.f ====
hw/menuPkg.sv
hw/localCharRam.sv
hw/inputDecoder.sv
hw/menuSequencer.sv
hw/lcdWriter.sv
hw/lcdMenuTop.sv
sim/tbClockGen.sv
sim/lcdMenuTb.sv

// ==== Bender.yml ====
package:
  name: lcd_menu

sources:
  - hw/menuPkg.sv
  - hw/localCharRam.sv
  - hw/inputDecoder.sv
  - hw/menuSequencer.sv
  - hw/lcdWriter.sv
  - hw/lcdMenuTop.sv
  - target: simulation
    files:
      - sim/tbClockGen.sv
      - sim/lcdMenuTb.sv
